// ==== mem_stage_defines.svh ====
`ifndef MEM_STAGE_DEFINES_SVH
`define MEM_STAGE_DEFINES_SVH

// RV32I memory opcodes
`define OPCODE_LOAD  7'b0000011
`define OPCODE_STORE 7'b0100011

// Data memory depth in 32-bit words, a power of two
`define DMEM_WORDS 256

// Word index width
`define DMEM_AW ($clog2(`DMEM_WORDS))

`endif

// ==== mem_stage_pkg.sv ====
`default_nettype none

`include "mem_stage_defines.svh"

package mem_stage_pkg;

    typedef logic [31:0] word_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // 00 word, 01 half, 10 byte, 11 none
    typedef logic [1:0]  access_size_t;

    // Bit 0 is the lowest-addressed byte
    typedef logic [3:0]  byte_en_t;

    typedef logic [`DMEM_AW-1:0] word_addr_t;

    localparam access_size_t SIZE_WORD = 2'b00;
    localparam access_size_t SIZE_HALF = 2'b01;
    localparam access_size_t SIZE_BYTE = 2'b10;
    localparam access_size_t SIZE_NONE = 2'b11;

endpackage

`default_nettype wire

// ==== mem_req_if.sv ====
`default_nettype none

interface mem_req_if;
    import mem_stage_pkg::*;

    access_size_t access_size;
    logic         write_en;
    logic         req;
    logic         load_unsigned;

    modport ctrl (
        output access_size,
        output write_en,
        output req,
        output load_unsigned
    );

    modport lsu (
        input access_size,
        input write_en,
        input req,
        input load_unsigned
    );

endinterface

`default_nettype wire

// ==== dmem_if.sv ====
`default_nettype none

interface dmem_if;
    import mem_stage_pkg::*;

    word_addr_t word_addr;
    byte_en_t   byte_en;
    word_t      wr_data;
    logic       rd_en;
    word_t      rd_data;

    modport lsu (
        output word_addr,
        output byte_en,
        output wr_data,
        output rd_en,
        input  rd_data
    );

    modport mem (
        input  word_addr,
        input  byte_en,
        input  wr_data,
        input  rd_en,
        output rd_data
    );

endinterface

`default_nettype wire

// ==== mem_ctrl.sv ====
`default_nettype none

`include "mem_stage_defines.svh"

module mem_ctrl (
    input  mem_stage_pkg::opcode_t opcode,
    input  mem_stage_pkg::funct3_t funct3,
    input  logic                   flush,
    mem_req_if.ctrl                req
);
    import mem_stage_pkg::*;

    logic is_load;
    logic is_store;

    // Loads look at funct3[1:0] only, bit 2 selects unsigned
    function automatic access_size_t load_size(input funct3_t f3);
        access_size_t size;
        case (f3[1:0])
            2'b00:   size = SIZE_BYTE;
            2'b01:   size = SIZE_HALF;
            2'b10:   size = SIZE_WORD;
            default: size = SIZE_NONE;
        endcase
        return size;
    endfunction

    // Stores need the full funct3 to be legal
    function automatic access_size_t store_size(input funct3_t f3);
        access_size_t size;
        case (f3)
            3'b000:  size = SIZE_BYTE;
            3'b001:  size = SIZE_HALF;
            3'b010:  size = SIZE_WORD;
            default: size = SIZE_NONE;
        endcase
        return size;
    endfunction

    assign is_load  = (opcode == `OPCODE_LOAD);
    assign is_store = (opcode == `OPCODE_STORE);

    always_comb begin
        if (is_load) begin
            req.access_size = load_size(funct3);
        end else if (is_store) begin
            req.access_size = store_size(funct3);
        end else begin
            // Not a memory instruction
            req.access_size = SIZE_NONE;
        end
    end

    // Flush kills stores only
    assign req.write_en = is_store && !flush;

    // A flushed store touches nothing, so it makes no request
    assign req.req = is_load || req.write_en;

    assign req.load_unsigned = funct3[2];

endmodule

`default_nettype wire

// ==== lsu.sv ====
`default_nettype none

`include "mem_stage_defines.svh"

module lsu (
    input  logic                 clk,
    input  logic                 arst_n,
    input  mem_stage_pkg::word_t addr,
    input  mem_stage_pkg::word_t store_data,
    mem_req_if.lsu               req,
    dmem_if.lsu                  dmem,
    output mem_stage_pkg::word_t load_data,
    output logic                 load_valid,
    output logic                 misaligned
);
    import mem_stage_pkg::*;

    logic         illegal;
    logic         unaligned;
    logic         access_ok;
    logic         do_store;
    logic         do_load;
    byte_en_t     lane_mask;
    word_t        lane_data;

    // Load context held for the cycle when rd_data returns
    logic         ld_valid_q;
    logic         bad_q;
    access_size_t ld_size_q;
    logic         ld_unsigned_q;
    logic [1:0]   ld_off_q;
    word_t        rd_shifted;
    word_t        rd_ext;

    assign illegal = (req.access_size == SIZE_NONE);

    always_comb begin
        case (req.access_size)
            SIZE_HALF: unaligned = addr[0];
            SIZE_WORD: unaligned = |addr[1:0];
            default:   unaligned = 1'b0;
        endcase
    end

    assign access_ok = req.req && !illegal && !unaligned;
    assign do_store  = access_ok && req.write_en;
    assign do_load   = access_ok && !req.write_en;

    // Lane enables and replicated store data
    always_comb begin
        case (req.access_size)
            SIZE_WORD: begin
                lane_mask = 4'b1111;
                lane_data = store_data;
            end
            SIZE_HALF: begin
                lane_mask = 4'b0011 << {addr[1], 1'b0};
                lane_data = {2{store_data[15:0]}};
            end
            SIZE_BYTE: begin
                lane_mask = 4'b0001 << addr[1:0];
                lane_data = {4{store_data[7:0]}};
            end
            default: begin
                lane_mask = 4'b0000;
                lane_data = store_data;
            end
        endcase
    end

    // Addresses wrap modulo the memory size
    assign dmem.word_addr = addr[`DMEM_AW+1:2];
    assign dmem.byte_en   = do_store ? lane_mask : 4'b0000;
    assign dmem.wr_data   = lane_data;
    assign dmem.rd_en     = do_load;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ld_valid_q <= 1'b0;
            bad_q      <= 1'b0;
        end else begin
            ld_valid_q <= do_load;
            bad_q      <= req.req && (illegal || unaligned);
        end
    end

    always_ff @(posedge clk) begin
        if (do_load) begin
            ld_size_q     <= req.access_size;
            ld_unsigned_q <= req.load_unsigned;
            ld_off_q      <= addr[1:0];
        end
    end

    // Bring the addressed byte or half down to bit 0
    assign rd_shifted = dmem.rd_data >> {ld_off_q, 3'b000};

    always_comb begin
        case (ld_size_q)
            SIZE_BYTE: begin
                if (ld_unsigned_q) begin
                    rd_ext = {24'd0, rd_shifted[7:0]};
                end else begin
                    rd_ext = {{24{rd_shifted[7]}}, rd_shifted[7:0]};
                end
            end
            SIZE_HALF: begin
                if (ld_unsigned_q) begin
                    rd_ext = {16'd0, rd_shifted[15:0]};
                end else begin
                    rd_ext = {{16{rd_shifted[15]}}, rd_shifted[15:0]};
                end
            end
            default: rd_ext = dmem.rd_data;
        endcase
    end

    // Zero between results
    assign load_data  = ld_valid_q ? rd_ext : '0;
    assign load_valid = ld_valid_q;
    assign misaligned = bad_q;

endmodule

`default_nettype wire

// ==== data_mem.sv ====
`default_nettype none

`include "mem_stage_defines.svh"

module data_mem (
    input  logic clk,
    dmem_if.mem  dmem
);
    import mem_stage_pkg::*;

    word_t mem [`DMEM_WORDS];

    // Byte-masked write, one word per cycle
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (dmem.byte_en[i]) begin
                mem[dmem.word_addr][8*i +: 8] <= dmem.wr_data[8*i +: 8];
            end
        end
    end

    // Synchronous read, result held until the next read
    always_ff @(posedge clk) begin
        if (dmem.rd_en) begin
            dmem.rd_data <= mem[dmem.word_addr];
        end
    end

endmodule

`default_nettype wire

// ==== mem_stage.sv ====
`default_nettype none

module mem_stage (
    input  logic                    clk,
    input  logic                    arst_n,
    input  mem_stage_pkg::opcode_t  opcode,
    input  mem_stage_pkg::funct3_t  funct3,
    input  logic                    flush,
    input  mem_stage_pkg::word_t    addr,
    input  mem_stage_pkg::word_t    store_data,
    output mem_stage_pkg::word_t    load_data,
    output logic                    load_valid,
    output logic                    misaligned
);

    mem_req_if u_req_if ();
    dmem_if    u_dmem_if ();

    // Instruction decode
    mem_ctrl u_mem_ctrl (
        .opcode (opcode),
        .funct3 (funct3),
        .flush  (flush),
        .req    (u_req_if.ctrl)
    );

    // Alignment, checks and load extension
    lsu u_lsu (
        .clk        (clk),
        .arst_n     (arst_n),
        .addr       (addr),
        .store_data (store_data),
        .req        (u_req_if.lsu),
        .dmem       (u_dmem_if.lsu),
        .load_data  (load_data),
        .load_valid (load_valid),
        .misaligned (misaligned)
    );

    data_mem u_data_mem (
        .clk  (clk),
        .dmem (u_dmem_if.mem)
    );

endmodule

`default_nettype wire

// ==== tb_mem_stage.sv ====
`default_nettype none

`include "mem_stage_defines.svh"

module tb_mem_stage;
    import mem_stage_pkg::*;

    localparam opcode_t OP_NOP = 7'b0010011;
    localparam int N_MIX = 2000;
    localparam int TOTAL_CYCLES = 16 + `DMEM_WORDS + 200 + 200 + 200 + 120 + 200 + N_MIX + 1;
    localparam int TIMEOUT = (TOTAL_CYCLES + 200) * 10;

    logic    clk = 1'b0;
    logic    arst_n;
    opcode_t opcode;
    funct3_t funct3;
    logic    flush;
    word_t   addr;
    word_t   store_data;
    word_t   load_data;
    logic    load_valid;
    logic    misaligned;

    // Reference memory, one entry per byte
    logic [7:0] ref_mem [4*`DMEM_WORDS];
    word_t      rng_state = 32'h3e1c;

    // Expected outputs for the cycle after the last applied instruction
    logic  exp_valid = 1'b0;
    logic  exp_flag = 1'b0;
    word_t exp_data = '0;

    always #5 clk = ~clk;

    mem_stage i_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .opcode     (opcode),
        .funct3     (funct3),
        .flush      (flush),
        .addr       (addr),
        .store_data (store_data),
        .load_data  (load_data),
        .load_valid (load_valid),
        .misaligned (misaligned)
    );

    function automatic word_t next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Upper LCG bits only, the low ones cycle quickly
    function automatic int rand_below(input int n);
        return int'((next_rand() >> 8) % word_t'(n));
    endfunction

    function automatic word_t rand32();
        word_t hi;
        word_t lo;
        hi = next_rand();
        lo = next_rand();
        return {hi[31:16], lo[31:16]};
    endfunction

    function automatic opcode_t other_opcode();
        opcode_t op;
        op = 7'(rand_below(128));
        while (op == `OPCODE_LOAD || op == `OPCODE_STORE) begin
            op = 7'(rand_below(128));
        end
        return op;
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string label);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s is %h, expected %h", $time, label, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "word check failed");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string label);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s is %b, expected %b", $time, label, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "flag check failed");
        end
    endtask

    // Access width in bytes, 0 for an invalid funct3 or a non-memory opcode
    function automatic int access_bytes(input opcode_t op, input funct3_t f3);
        int n;
        n = 0;
        if (op == `OPCODE_LOAD) begin
            n = (f3[1:0] == 2'b00) ? 1 : (f3[1:0] == 2'b01) ? 2 : (f3[1:0] == 2'b10) ? 4 : 0;
        end else if (op == `OPCODE_STORE) begin
            n = (f3 == 3'b000) ? 1 : (f3 == 3'b001) ? 2 : (f3 == 3'b010) ? 4 : 0;
        end
        return n;
    endfunction

    task automatic model_step(input opcode_t op, input funct3_t f3, input logic fl,
                              input word_t a, input word_t d);
        int         n;
        logic       wr;
        logic       active;
        logic       bad;
        word_addr_t widx;
        logic [1:0] lane;
        word_t      v;
        n      = access_bytes(op, f3);
        wr     = (op == `OPCODE_STORE) && !fl;
        active = (op == `OPCODE_LOAD) || wr;
        bad    = active && (n == 0 || (n == 2 && a[0]) || (n == 4 && a[1:0] != 2'b00));
        widx   = a[`DMEM_AW+1:2];
        v      = '0;
        exp_flag  = bad;
        exp_valid = 1'b0;
        exp_data  = '0;
        if (active && !bad) begin
            for (int k = 0; k < n; k++) begin
                lane = a[1:0] + 2'(k);
                if (wr) begin
                    ref_mem[{widx, lane}] = d[8*k +: 8];
                end else begin
                    v[8*k +: 8] = ref_mem[{widx, lane}];
                end
            end
            if (!wr) begin
                if (n == 1 && !f3[2]) begin
                    v = {{24{v[7]}}, v[7:0]};
                end else if (n == 2 && !f3[2]) begin
                    v = {{16{v[15]}}, v[15:0]};
                end
                exp_valid = 1'b1;
                exp_data  = v;
            end
        end
    endtask

    // One instruction per cycle, results of the previous one checked at negedge
    task automatic apply(input opcode_t op, input funct3_t f3, input logic fl,
                         input word_t a, input word_t d);
        @(posedge clk);
        opcode     <= op;
        funct3     <= f3;
        flush      <= fl;
        addr       <= a;
        store_data <= d;
        @(negedge clk);
        check_flag(load_valid, exp_valid, "load_valid");
        check_flag(misaligned, exp_flag, "misaligned");
        check_word(load_data, exp_data, "load_data");
        model_step(op, f3, fl, a, d);
    endtask

    initial begin
        #(TIMEOUT);
        $display("Timeout: the test sequence did not finish within %0d time units", TIMEOUT);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

    initial begin
        word_t   a;
        funct3_t f3;
        opcode_t op;
        int      kind;
        arst_n     <= 1'b0;
        opcode     <= OP_NOP;
        funct3     <= 3'b000;
        flush      <= 1'b0;
        addr       <= '0;
        store_data <= '0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;

        // Fill every word, then random word readback
        for (int w = 0; w < `DMEM_WORDS; w++) begin
            apply(`OPCODE_STORE, 3'b010, 1'b0, word_t'(w) << 2, rand32());
        end
        for (int i = 0; i < 200; i++) begin
            apply(`OPCODE_LOAD, 3'b010, 1'b0, word_t'(rand_below(`DMEM_WORDS)) << 2, '0);
        end

        // SB and SH merged into a word
        for (int i = 0; i < 100; i++) begin
            a  = rand32();
            f3 = 3'(rand_below(2));
            if (f3 == 3'b001) begin
                a[0] = 1'b0;
            end
            apply(`OPCODE_STORE, f3, 1'b0, a, rand32());
            apply(`OPCODE_LOAD, 3'b010, 1'b0, {a[31:2], 2'b00}, '0);
        end

        // LB, LBU, LH, LHU
        for (int i = 0; i < 200; i++) begin
            a  = rand32();
            f3 = {rand_below(2) == 1, 2'(rand_below(2))};
            if (f3[0]) begin
                a[0] = 1'b0;
            end
            apply(`OPCODE_LOAD, f3, 1'b0, a, '0);
        end

        // Misaligned half and word accesses, then readback
        for (int i = 0; i < 60; i++) begin
            kind = rand_below(4);
            a    = rand32();
            if (kind[0]) begin
                f3 = 3'b010;
                if (a[1:0] == 2'b00) begin
                    a[1:0] = 2'(1 + rand_below(3));
                end
            end else begin
                f3   = 3'b001;
                a[0] = 1'b1;
            end
            op = kind[1] ? `OPCODE_STORE : `OPCODE_LOAD;
            apply(op, f3, 1'b0, a, rand32());
            apply(`OPCODE_LOAD, 3'b010, 1'b0, {a[31:2], 2'b00}, '0);
        end

        // Flushed stores, other opcodes, illegal funct3
        for (int i = 0; i < 50; i++) begin
            a = rand32();
            apply(`OPCODE_STORE, 3'(rand_below(8)), 1'b1, a, rand32());
            apply(other_opcode(), 3'(rand_below(8)), rand_below(2) == 1, rand32(), rand32());
            if (rand_below(2) == 1) begin
                apply(`OPCODE_STORE, 3'(3 + rand_below(5)), 1'b0, rand32(), rand32());
            end else begin
                apply(`OPCODE_LOAD, {rand_below(2) == 1, 2'b11}, 1'b0, rand32(), '0);
            end
            apply(`OPCODE_LOAD, 3'b010, 1'b0, {a[31:2], 2'b00}, '0);
        end

        // Mixed traffic over the full address space
        for (int i = 0; i < N_MIX; i++) begin
            kind = rand_below(8);
            a    = rand32();
            f3   = 3'(rand_below(8));
            if (rand_below(4) != 0) begin
                // Mostly legal and aligned
                f3[1:0] = 2'(rand_below(3));
                if (kind >= 3) begin
                    f3[2] = 1'b0;
                end
                if (f3[1:0] == 2'b01) begin
                    a[0] = 1'b0;
                end else if (f3[1:0] == 2'b10) begin
                    a[1:0] = 2'b00;
                end
            end
            if (kind < 3) begin
                op = `OPCODE_LOAD;
            end else if (kind < 7) begin
                op = `OPCODE_STORE;
            end else begin
                op = other_opcode();
            end
            apply(op, f3, rand_below(8) == 0, a, rand32());
        end

        apply(OP_NOP, 3'b000, 1'b0, '0, '0);
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
mem_stage_pkg.sv
mem_req_if.sv
dmem_if.sv
mem_ctrl.sv
lsu.sv
data_mem.sv
mem_stage.sv
tb_mem_stage.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_mem_stage -f project.f
./obj_dir/Vtb_mem_stage
